// File: hdl/axi_bridge_consts.svh
`ifndef AXI_BRIDGE_CONSTS_SVH
`define AXI_BRIDGE_CONSTS_SVH

// Bus widths
`define AXI_ADDR_W 32
`define LINE_W 128
`define STRB_W 16
`define AXI_ID_W 4

// Read IDs select the client on the R channel
`define ICACHE_RD_ID 0
`define DCACHE_RD_ID 1

// Only the data cache writes
`define DCACHE_WR_ID 1

// One 16-byte beat per transfer
`define AXI_SIZE_LINE 3'd4

// INCR burst encoding
`define AXI_BURST_INCR 2'd1

`endif

// File: hdl/axi_bridge_pkg.sv
`include "axi_bridge_consts.svh"

`default_nettype none

package axi_bridge_pkg;

    // Byte address on the AXI bus
    typedef logic [`AXI_ADDR_W-1:0] addr_t;

    // One full cache line, moved in a single beat
    typedef logic [`LINE_W-1:0] line_t;

    // Byte enables for a line write
    typedef logic [`STRB_W-1:0] strb_t;

    // Transaction ID
    typedef logic [`AXI_ID_W-1:0] axi_id_t;

    // Read clients sharing the AR channel
    typedef enum logic {
        RD_ICACHE = 1'b0,
        RD_DCACHE = 1'b1
    } rd_client_e;

endpackage

`default_nettype wire

// File: hdl/cache_bus_if.sv
`default_nettype none

// Line read port between a cache and the read engine
interface cache_rd_if;
    import axi_bridge_pkg::*;

    logic  req;
    addr_t addr;
    logic  rdy;
    logic  ret_valid;
    line_t ret_data;

    modport client (
        output req,
        output addr,
        input  rdy,
        input  ret_valid,
        input  ret_data
    );

    modport engine (
        input  req,
        input  addr,
        output rdy,
        output ret_valid,
        output ret_data
    );
endinterface

// Line write port between the data cache and the write engine
interface cache_wr_if;
    import axi_bridge_pkg::*;

    logic  req;
    addr_t addr;
    strb_t wstrb;
    line_t data;
    logic  rdy;

    modport client (
        output req,
        output addr,
        output wstrb,
        output data,
        input  rdy
    );

    modport engine (
        input  req,
        input  addr,
        input  wstrb,
        input  data,
        output rdy
    );
endinterface

`default_nettype wire

// File: hdl/axi_read_engine.sv
`include "axi_bridge_consts.svh"

`default_nettype none

module axi_read_engine (
    input  logic                    clk,
    input  logic                    reset_i,

    cache_rd_if.engine              icache,
    cache_rd_if.engine              dcache,

    output logic                    arvalid_o,
    output axi_bridge_pkg::addr_t   araddr_o,
    output axi_bridge_pkg::axi_id_t arid_o,
    input  logic                    arready_i,

    input  logic                    rvalid_i,
    input  axi_bridge_pkg::axi_id_t rid_i,
    input  axi_bridge_pkg::line_t   rdata_i
);
    import axi_bridge_pkg::*;

    localparam axi_id_t IC_ID = axi_id_t'(`ICACHE_RD_ID);
    localparam axi_id_t DC_ID = axi_id_t'(`DCACHE_RD_ID);

    // One read in flight per client
    logic ic_pend_q;
    logic dc_pend_q;

    // Registered return strobes and the shared return line
    logic  ic_ret_q;
    logic  dc_ret_q;
    line_t ret_data_q;

    logic       ar_free;
    logic       ic_take;
    logic       dc_take;
    logic       r_ic;
    logic       r_dc;
    rd_client_e grant;

    // AR register can take a new request when empty or draining now
    assign ar_free = !arvalid_o || arready_i;

    // Data cache wins a same-cycle contest
    assign dcache.rdy = !dc_pend_q && ar_free;
    assign icache.rdy = !ic_pend_q && ar_free && !dcache.req;

    assign dc_take = dcache.req && dcache.rdy;
    assign ic_take = icache.req && icache.rdy;
    assign grant   = dc_take ? RD_DCACHE : RD_ICACHE;

    // R beat owner, decoded from rid
    assign r_ic = rvalid_i && (rid_i == IC_ID);
    assign r_dc = rvalid_i && (rid_i == DC_ID);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            arvalid_o <= 1'b0;
        end else if (ic_take || dc_take) begin
            arvalid_o <= 1'b1;
        end else if (arready_i) begin
            arvalid_o <= 1'b0;
        end
    end

    // AR fields only change when a new request is taken
    always_ff @(posedge clk) begin
        if (ic_take || dc_take) begin
            case (grant)
                RD_DCACHE: begin
                    araddr_o <= dcache.addr;
                    arid_o   <= DC_ID;
                end
                default: begin
                    araddr_o <= icache.addr;
                    arid_o   <= IC_ID;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ic_pend_q <= 1'b0;
            dc_pend_q <= 1'b0;
        end else begin
            if (ic_take) begin
                ic_pend_q <= 1'b1;
            end else if (r_ic) begin
                ic_pend_q <= 1'b0;
            end
            if (dc_take) begin
                dc_pend_q <= 1'b1;
            end else if (r_dc) begin
                dc_pend_q <= 1'b0;
            end
        end
    end

    // Return pulse lands one cycle after the R handshake
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ic_ret_q <= 1'b0;
            dc_ret_q <= 1'b0;
        end else begin
            ic_ret_q <= r_ic;
            dc_ret_q <= r_dc;
        end
    end

    // Only one R beat per cycle, so both clients share this register
    always_ff @(posedge clk) begin
        if (rvalid_i) begin
            ret_data_q <= rdata_i;
        end
    end

    assign icache.ret_valid = ic_ret_q;
    assign icache.ret_data  = ret_data_q;
    assign dcache.ret_valid = dc_ret_q;
    assign dcache.ret_data  = ret_data_q;

    // A stalled AR keeps its address and ID
    a_ar_hold: assert property (
        @(posedge clk) disable iff (reset_i)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o) && $stable(arid_o)
    ) else $error("AR fields changed while stalled");

    // Slave may only return reads that are in flight
    a_r_owner: assert property (
        @(posedge clk) disable iff (reset_i)
        rvalid_i |-> (r_ic && ic_pend_q) || (r_dc && dc_pend_q)
    ) else $error("R beat with no outstanding read for rid %0d", rid_i);

endmodule

`default_nettype wire

// File: hdl/axi_write_engine.sv
`default_nettype none

module axi_write_engine (
    input  logic                  clk,
    input  logic                  reset_i,

    cache_wr_if.engine            dcache,

    output logic                  awvalid_o,
    output axi_bridge_pkg::addr_t awaddr_o,
    input  logic                  awready_i,

    output logic                  wvalid_o,
    output axi_bridge_pkg::line_t wdata_o,
    output axi_bridge_pkg::strb_t wstrb_o,
    input  logic                  wready_i,

    input  logic                  bvalid_i
);

    // Set from acceptance until the B response
    logic pend_q;
    logic take;
    logic b_done;

    assign dcache.rdy = !pend_q;
    assign take       = dcache.req && !pend_q;
    assign b_done     = bvalid_i && pend_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pend_q <= 1'b0;
        end else if (take) begin
            pend_q <= 1'b1;
        end else if (b_done) begin
            pend_q <= 1'b0;
        end
    end

    // Address phase, cleared by its own handshake
    always_ff @(posedge clk) begin
        if (reset_i) begin
            awvalid_o <= 1'b0;
        end else if (take) begin
            awvalid_o <= 1'b1;
        end else if (awready_i) begin
            awvalid_o <= 1'b0;
        end
    end

    // Data phase runs independently of the address phase
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wvalid_o <= 1'b0;
        end else if (take) begin
            wvalid_o <= 1'b1;
        end else if (wready_i) begin
            wvalid_o <= 1'b0;
        end
    end

    // Captured write, held until the next acceptance
    always_ff @(posedge clk) begin
        if (take) begin
            awaddr_o <= dcache.addr;
            wdata_o  <= dcache.data;
            wstrb_o  <= dcache.wstrb;
        end
    end

    // B follows both completed phases of the pending write
    a_b_after_phases: assert property (
        @(posedge clk) disable iff (reset_i)
        bvalid_i |-> pend_q && !awvalid_o && !wvalid_o
    ) else $error("B response without a completed pending write");

endmodule

`default_nettype wire

// File: hdl/axi_bridge.sv
`include "axi_bridge_consts.svh"

`default_nettype none

module axi_bridge (
    input  logic                    clk,
    input  logic                    reset_i,

    // Instruction line fetch
    input  logic                    icache_rd_req_i,
    input  axi_bridge_pkg::addr_t   icache_rd_addr_i,
    output logic                    icache_rd_rdy_o,
    output logic                    icache_rd_ret_valid_o,
    output axi_bridge_pkg::line_t   icache_rd_ret_data_o,

    // Data line fetch
    input  logic                    dcache_rd_req_i,
    input  axi_bridge_pkg::addr_t   dcache_rd_addr_i,
    output logic                    dcache_rd_rdy_o,
    output logic                    dcache_rd_ret_valid_o,
    output axi_bridge_pkg::line_t   dcache_rd_ret_data_o,

    // Data line write
    input  logic                    dcache_wr_req_i,
    input  axi_bridge_pkg::addr_t   dcache_wr_addr_i,
    input  axi_bridge_pkg::strb_t   dcache_wr_wstrb_i,
    input  axi_bridge_pkg::line_t   dcache_wr_data_i,
    output logic                    dcache_wr_rdy_o,

    // AR channel
    output axi_bridge_pkg::axi_id_t arid_o,
    output axi_bridge_pkg::addr_t   araddr_o,
    output logic [7:0]              arlen_o,
    output logic [2:0]              arsize_o,
    output logic [1:0]              arburst_o,
    output logic [1:0]              arlock_o,
    output logic [3:0]              arcache_o,
    output logic [2:0]              arprot_o,
    output logic                    arvalid_o,
    input  logic                    arready_i,

    // R channel
    input  axi_bridge_pkg::axi_id_t rid_i,
    input  axi_bridge_pkg::line_t   rdata_i,
    input  logic [1:0]              rresp_i,
    input  logic                    rlast_i,
    input  logic                    rvalid_i,
    output logic                    rready_o,

    // AW channel
    output axi_bridge_pkg::axi_id_t awid_o,
    output axi_bridge_pkg::addr_t   awaddr_o,
    output logic [7:0]              awlen_o,
    output logic [2:0]              awsize_o,
    output logic [1:0]              awburst_o,
    output logic [1:0]              awlock_o,
    output logic [3:0]              awcache_o,
    output logic [2:0]              awprot_o,
    output logic                    awvalid_o,
    input  logic                    awready_i,

    // W channel
    output axi_bridge_pkg::axi_id_t wid_o,
    output axi_bridge_pkg::line_t   wdata_o,
    output axi_bridge_pkg::strb_t   wstrb_o,
    output logic                    wlast_o,
    output logic                    wvalid_o,
    input  logic                    wready_i,

    // B channel
    input  axi_bridge_pkg::axi_id_t bid_i,
    input  logic [1:0]              bresp_i,
    input  logic                    bvalid_i,
    output logic                    bready_o
);
    import axi_bridge_pkg::*;

    localparam axi_id_t WR_ID = axi_id_t'(`DCACHE_WR_ID);

    cache_rd_if icache_rd ();
    cache_rd_if dcache_rd ();
    cache_wr_if dcache_wr ();

    // Client pins onto the internal ports
    assign icache_rd.req         = icache_rd_req_i;
    assign icache_rd.addr        = icache_rd_addr_i;
    assign icache_rd_rdy_o       = icache_rd.rdy;
    assign icache_rd_ret_valid_o = icache_rd.ret_valid;
    assign icache_rd_ret_data_o  = icache_rd.ret_data;

    assign dcache_rd.req         = dcache_rd_req_i;
    assign dcache_rd.addr        = dcache_rd_addr_i;
    assign dcache_rd_rdy_o       = dcache_rd.rdy;
    assign dcache_rd_ret_valid_o = dcache_rd.ret_valid;
    assign dcache_rd_ret_data_o  = dcache_rd.ret_data;

    assign dcache_wr.req         = dcache_wr_req_i;
    assign dcache_wr.addr        = dcache_wr_addr_i;
    assign dcache_wr.wstrb       = dcache_wr_wstrb_i;
    assign dcache_wr.data        = dcache_wr_data_i;
    assign dcache_wr_rdy_o       = dcache_wr.rdy;

    // Single-beat line transfers
    assign arlen_o   = '0;
    assign arsize_o  = `AXI_SIZE_LINE;
    assign arburst_o = `AXI_BURST_INCR;
    assign arlock_o  = '0;
    assign arcache_o = '0;
    assign arprot_o  = '0;

    assign awid_o    = WR_ID;
    assign awlen_o   = '0;
    assign awsize_o  = `AXI_SIZE_LINE;
    assign awburst_o = `AXI_BURST_INCR;
    assign awlock_o  = '0;
    assign awcache_o = '0;
    assign awprot_o  = '0;

    assign wid_o     = WR_ID;
    assign wlast_o   = 1'b1;

    // Clients take returns at any time
    assign rready_o  = 1'b1;
    assign bready_o  = 1'b1;

    axi_read_engine u_read_engine (
        .clk       (clk),
        .reset_i   (reset_i),
        .icache    (icache_rd.engine),
        .dcache    (dcache_rd.engine),
        .arvalid_o (arvalid_o),
        .araddr_o  (araddr_o),
        .arid_o    (arid_o),
        .arready_i (arready_i),
        .rvalid_i  (rvalid_i),
        .rid_i     (rid_i),
        .rdata_i   (rdata_i)
    );

    axi_write_engine u_write_engine (
        .clk       (clk),
        .reset_i   (reset_i),
        .dcache    (dcache_wr.engine),
        .awvalid_o (awvalid_o),
        .awaddr_o  (awaddr_o),
        .awready_i (awready_i),
        .wvalid_o  (wvalid_o),
        .wdata_o   (wdata_o),
        .wstrb_o   (wstrb_o),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i)
    );

    // Slave side framing of single-beat traffic
    a_r_single_beat: assert property (
        @(posedge clk) disable iff (reset_i)
        rvalid_i |-> rlast_i
    ) else $error("R beat without rlast on a single-beat read");

    a_b_id: assert property (
        @(posedge clk) disable iff (reset_i)
        bvalid_i |-> bid_i == WR_ID
    ) else $error("B response with unexpected bid %0d", bid_i);

endmodule

`default_nettype wire

// File: verification/axi_mem_model.sv
`include "axi_bridge_consts.svh"

`default_nettype none

// AXI slave line memory with optional ready stalls and reordered returns
module axi_mem_model (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    stall_i,
    input  logic                    reverse_i,

    input  logic                    arvalid_i,
    input  axi_bridge_pkg::addr_t   araddr_i,
    input  axi_bridge_pkg::axi_id_t arid_i,
    output logic                    arready_o,

    output logic                    rvalid_o,
    output axi_bridge_pkg::axi_id_t rid_o,
    output axi_bridge_pkg::line_t   rdata_o,
    output logic                    rlast_o,
    output logic [1:0]              rresp_o,

    input  logic                    awvalid_i,
    input  axi_bridge_pkg::addr_t   awaddr_i,
    output logic                    awready_o,

    input  logic                    wvalid_i,
    input  axi_bridge_pkg::line_t   wdata_i,
    input  axi_bridge_pkg::strb_t   wstrb_i,
    output logic                    wready_o,

    output logic                    bvalid_o,
    output axi_bridge_pkg::axi_id_t bid_o,
    output logic [1:0]              bresp_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import axi_bridge_pkg::*;

    // Written lines, indexed by line address
    line_t   mem [logic [27:0]];
    addr_t   rd_addr_q [$];
    axi_id_t rd_id_q [$];

    addr_t aw_addr;
    line_t w_data;
    strb_t w_strb;
    logic  aw_got;
    logic  w_got;
    logic  pair_done;
    int    idx;

    // Handshakes seen at the last rising edge
    logic    ar_hs;
    addr_t   ar_addr_s;
    axi_id_t ar_id_s;
    logic    aw_hs;
    addr_t   aw_addr_s;
    logic    w_hs;
    line_t   w_data_s;
    strb_t   w_strb_s;

    // Unwritten lines hold a pattern of the full line address
    function automatic line_t fill_line(logic [27:0] key);
        logic [31:0] w;
        w = {4'h0, key};
        return {w * 32'h9e37_79b9, ~w, w ^ 32'h5a5a_a5a5, w + 32'h0101_0101};
    endfunction

    function automatic line_t read_line(addr_t a);
        if (mem.exists(a[31:4])) begin
            return mem[a[31:4]];
        end
        return fill_line(a[31:4]);
    endfunction

    initial begin
        arready_o = 1'b1;
        awready_o = 1'b1;
        wready_o  = 1'b1;
        rvalid_o  = 1'b0;
        rid_o     = '0;
        rdata_o   = '0;
        rlast_o   = 1'b1;
        rresp_o   = 2'b00;
        bvalid_o  = 1'b0;
        bid_o     = axi_id_t'(`DCACHE_WR_ID);
        bresp_o   = 2'b00;
        aw_got    = 1'b0;
        w_got     = 1'b0;
        pair_done = 1'b0;
        ar_hs     = 1'b0;
        aw_hs     = 1'b0;
        w_hs      = 1'b0;
    end

    // Handshakes are taken at the rising edge
    always @(posedge clk) begin
        ar_hs     = !reset_i && arvalid_i && arready_o;
        ar_addr_s = araddr_i;
        ar_id_s   = arid_i;
        aw_hs     = !reset_i && awvalid_i && awready_o;
        aw_addr_s = awaddr_i;
        w_hs      = !reset_i && wvalid_i && wready_o;
        w_data_s  = wdata_i;
        w_strb_s  = wstrb_i;
    end

    // Outputs change on the falling edge
    always @(negedge clk) begin
        line_t l;
        arready_o = !stall_i || ($urandom % 2 == 0);
        awready_o = !stall_i || ($urandom % 2 == 0);
        wready_o  = !stall_i || ($urandom % 2 == 0);
        rvalid_o  = 1'b0;
        idx       = -1;
        if (reset_i) begin
            bvalid_o = 1'b0;
            aw_got   = 1'b0;
            w_got    = 1'b0;
            rd_addr_q.delete();
            rd_id_q.delete();
        end else begin
            if (ar_hs) begin
                rd_addr_q.push_back(ar_addr_s);
                rd_id_q.push_back(ar_id_s);
            end
            if (aw_hs) begin
                aw_addr = aw_addr_s;
                aw_got  = 1'b1;
            end
            if (w_hs) begin
                w_data = w_data_s;
                w_strb = w_strb_s;
                w_got  = 1'b1;
            end
            if (!reverse_i) begin
                pair_done = 1'b0;
                if (rd_addr_q.size() > 0 && (!stall_i || $urandom % 2 == 0)) begin
                    idx = 0;
                end
            end else if (rd_addr_q.size() >= 2) begin
                // Newest read overtakes the older one
                idx       = rd_addr_q.size() - 1;
                pair_done = 1'b1;
            end else if (pair_done && rd_addr_q.size() > 0) begin
                idx = 0;
            end
            if (idx >= 0) begin
                rvalid_o = 1'b1;
                rid_o    = rd_id_q[idx];
                rdata_o  = read_line(rd_addr_q[idx]);
                rd_addr_q.delete(idx);
                rd_id_q.delete(idx);
            end
            if (bvalid_o) begin
                bvalid_o = 1'b0;
            end else if (aw_got && w_got) begin
                l = read_line(aw_addr);
                for (int b = 0; b < 16; b++) begin
                    if (w_strb[b]) begin
                        l[b*8 +: 8] = w_data[b*8 +: 8];
                    end
                end
                mem[aw_addr[31:4]] = l;
                aw_got   = 1'b0;
                w_got    = 1'b0;
                bvalid_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/axi_bridge_tb.sv
`include "axi_bridge_consts.svh"

`default_nettype none

module axi_bridge_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import axi_bridge_pkg::*;

    localparam int NUM_TESTS   = 5;
    localparam int PER_TEST_NS = 20000;

    logic clk;
    logic reset_i;
    logic stall;
    logic reverse;

    logic ic_req, ic_rdy, ic_ret_valid;
    logic dc_req, dc_rdy, dc_ret_valid;
    logic wr_req, wr_rdy;
    addr_t ic_addr, dc_addr, wr_addr;
    line_t ic_ret_data, dc_ret_data, wr_data;
    strb_t wr_strb;

    axi_id_t arid, rid, awid, wid, bid;
    addr_t araddr, awaddr;
    line_t rdata, wdata;
    strb_t wstrb;
    logic [7:0] arlen, awlen;
    logic [2:0] arsize, awsize, arprot, awprot;
    logic [1:0] arburst, awburst, arlock, awlock, rresp, bresp;
    logic [3:0] arcache, awcache;
    logic arvalid, arready, rvalid, rlast, rready;
    logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;

    int checks;
    int errors;

    // Lines the testbench has written, by line address
    line_t shadow [logic [27:0]];

    axi_bridge DUT (
        .clk(clk), .reset_i(reset_i),
        .icache_rd_req_i(ic_req), .icache_rd_addr_i(ic_addr),
        .icache_rd_rdy_o(ic_rdy), .icache_rd_ret_valid_o(ic_ret_valid),
        .icache_rd_ret_data_o(ic_ret_data),
        .dcache_rd_req_i(dc_req), .dcache_rd_addr_i(dc_addr),
        .dcache_rd_rdy_o(dc_rdy), .dcache_rd_ret_valid_o(dc_ret_valid),
        .dcache_rd_ret_data_o(dc_ret_data),
        .dcache_wr_req_i(wr_req), .dcache_wr_addr_i(wr_addr),
        .dcache_wr_wstrb_i(wr_strb), .dcache_wr_data_i(wr_data),
        .dcache_wr_rdy_o(wr_rdy),
        .arid_o(arid), .araddr_o(araddr), .arlen_o(arlen), .arsize_o(arsize),
        .arburst_o(arburst), .arlock_o(arlock), .arcache_o(arcache),
        .arprot_o(arprot), .arvalid_o(arvalid), .arready_i(arready),
        .rid_i(rid), .rdata_i(rdata), .rresp_i(rresp), .rlast_i(rlast),
        .rvalid_i(rvalid), .rready_o(rready),
        .awid_o(awid), .awaddr_o(awaddr), .awlen_o(awlen), .awsize_o(awsize),
        .awburst_o(awburst), .awlock_o(awlock), .awcache_o(awcache),
        .awprot_o(awprot), .awvalid_o(awvalid), .awready_i(awready),
        .wid_o(wid), .wdata_o(wdata), .wstrb_o(wstrb), .wlast_o(wlast),
        .wvalid_o(wvalid), .wready_i(wready),
        .bid_i(bid), .bresp_i(bresp), .bvalid_i(bvalid), .bready_o(bready)
    );

    axi_mem_model mem (
        .clk(clk), .reset_i(reset_i), .stall_i(stall), .reverse_i(reverse),
        .arvalid_i(arvalid), .araddr_i(araddr), .arid_i(arid), .arready_o(arready),
        .rvalid_o(rvalid), .rid_o(rid), .rdata_o(rdata), .rlast_o(rlast),
        .rresp_o(rresp),
        .awvalid_i(awvalid), .awaddr_i(awaddr), .awready_o(awready),
        .wvalid_i(wvalid), .wdata_i(wdata), .wstrb_i(wstrb), .wready_o(wready),
        .bvalid_o(bvalid), .bid_o(bid), .bresp_o(bresp)
    );

    always #4 clk = !clk;

    task automatic check_line(string name, line_t got, line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_strb(string name, strb_t got, strb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_id(string name, axi_id_t got, axi_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_field(string name, logic [7:0] got, logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Memory contents before any write, a function of the line address
    function automatic line_t expected_line(addr_t a);
        logic [31:0] w;
        if (shadow.exists(a[31:4])) begin
            return shadow[a[31:4]];
        end
        w = {4'h0, a[31:4]};
        return {w * 32'h9e37_79b9, ~w, w ^ 32'h5a5a_a5a5, w + 32'h0101_0101};
    endfunction

    // Sample point, two ns before the rising edge
    task automatic settle();
        @(negedge clk);
        #2;
    endtask

    task automatic issue_read(logic is_dc, addr_t a);
        @(negedge clk);
        if (is_dc) begin
            dc_req  = 1'b1;
            dc_addr = a;
        end else begin
            ic_req  = 1'b1;
            ic_addr = a;
        end
        #2;
        while (is_dc ? !dc_rdy : !ic_rdy) begin
            settle();
        end
        @(negedge clk);
        ic_req = 1'b0;
        dc_req = 1'b0;
        #2;
    endtask

    task automatic read_line(logic is_dc, addr_t a);
        logic ar_seen;
        logic got;
        line_t exp;
        ar_seen = 1'b0;
        got     = 1'b0;
        exp     = expected_line(a);
        issue_read(is_dc, a);
        while (!got) begin
            if (arvalid && !ar_seen) begin
                check_addr("araddr", araddr, a);
                check_id("arid", arid, is_dc ? axi_id_t'(`DCACHE_RD_ID)
                                             : axi_id_t'(`ICACHE_RD_ID));
                ar_seen = 1'b1;
            end
            if (is_dc ? dc_ret_valid : ic_ret_valid) begin
                check_line(is_dc ? "dcache_rd_ret_data" : "icache_rd_ret_data",
                           is_dc ? dc_ret_data : ic_ret_data, exp);
                got = 1'b1;
            end else begin
                settle();
            end
        end
    endtask

    task automatic write_line(addr_t a, strb_t s, line_t d);
        logic aw_seen;
        logic w_seen;
        logic b_seen;
        line_t l;
        aw_seen = 1'b0;
        w_seen  = 1'b0;
        b_seen  = 1'b0;
        @(negedge clk);
        wr_req  = 1'b1;
        wr_addr = a;
        wr_strb = s;
        wr_data = d;
        #2;
        while (!wr_rdy) begin
            settle();
        end
        @(negedge clk);
        wr_req = 1'b0;
        #2;
        l = expected_line(a);
        for (int b = 0; b < 16; b++) begin
            if (s[b]) begin
                l[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        shadow[a[31:4]] = l;
        while (!b_seen) begin
            check_bit("dcache_wr_rdy", wr_rdy, 1'b0);
            if (awvalid && !aw_seen) begin
                check_addr("awaddr", awaddr, a);
                check_id("awid", awid, axi_id_t'(`DCACHE_WR_ID));
                check_field("awlen", awlen, 8'd0);
                check_field("awsize", {5'd0, awsize}, {5'd0, `AXI_SIZE_LINE});
                check_field("awburst", {6'd0, awburst}, {6'd0, `AXI_BURST_INCR});
                check_field("awlock", {6'd0, awlock}, 8'd0);
                check_field("awcache", {4'd0, awcache}, 8'd0);
                check_field("awprot", {5'd0, awprot}, 8'd0);
                aw_seen = 1'b1;
            end
            if (wvalid && !w_seen) begin
                check_line("wdata", wdata, d);
                check_strb("wstrb", wstrb, s);
                check_id("wid", wid, axi_id_t'(`DCACHE_WR_ID));
                check_bit("wlast", wlast, 1'b1);
                w_seen = 1'b1;
            end
            b_seen = bvalid;
            settle();
        end
        check_bit("dcache_wr_rdy", wr_rdy, 1'b1);
    endtask

    task automatic reset_state();
        check_bit("arvalid", arvalid, 1'b0);
        check_bit("awvalid", awvalid, 1'b0);
        check_bit("wvalid", wvalid, 1'b0);
        check_bit("icache_rd_ret_valid", ic_ret_valid, 1'b0);
        check_bit("dcache_rd_ret_valid", dc_ret_valid, 1'b0);
        check_bit("icache_rd_rdy", ic_rdy, 1'b1);
        check_bit("dcache_rd_rdy", dc_rdy, 1'b1);
        check_bit("dcache_wr_rdy", wr_rdy, 1'b1);
        check_bit("rready", rready, 1'b1);
        check_bit("bready", bready, 1'b1);
    endtask

    task automatic icache_fetch();
        read_line(1'b0, 32'h0000_1230);
        check_field("arlen", arlen, 8'd0);
        check_field("arsize", {5'd0, arsize}, {5'd0, `AXI_SIZE_LINE});
        check_field("arburst", {6'd0, arburst}, {6'd0, `AXI_BURST_INCR});
        check_field("arlock", {6'd0, arlock}, 8'd0);
        check_field("arcache", {4'd0, arcache}, 8'd0);
        check_field("arprot", {5'd0, arprot}, 8'd0);
    endtask

    task automatic write_then_read();
        write_line(32'h0000_4560, 16'h0ff1, 128'hdead_beef_0123_4567_89ab_cdef_f00d_cafe);
        read_line(1'b1, 32'h0000_4560);
    endtask

    task automatic dual_read();
        logic ic_got;
        logic dc_got;
        logic ic_first;
        ic_got   = 1'b0;
        dc_got   = 1'b0;
        ic_first = 1'b0;
        reverse  = 1'b1;
        @(negedge clk);
        ic_req  = 1'b1;
        ic_addr = 32'h0000_7700;
        dc_req  = 1'b1;
        dc_addr = 32'h0000_8800;
        #2;
        check_bit("dcache_rd_rdy", dc_rdy, 1'b1);
        check_bit("icache_rd_rdy", ic_rdy, 1'b0);
        @(negedge clk);
        dc_req = 1'b0;
        #2;
        while (!ic_rdy) begin
            settle();
        end
        @(negedge clk);
        ic_req = 1'b0;
        #2;
        while (!(ic_got && dc_got)) begin
            if (ic_ret_valid) begin
                check_line("icache_rd_ret_data", ic_ret_data, expected_line(32'h0000_7700));
                ic_first = !dc_got;
                ic_got   = 1'b1;
            end
            if (dc_ret_valid) begin
                check_line("dcache_rd_ret_data", dc_ret_data, expected_line(32'h0000_8800));
                dc_got = 1'b1;
            end
            settle();
        end
        // The model returns the later instruction read first
        check_bit("icache returned first", ic_first, 1'b1);
        reverse = 1'b0;
    endtask

    task automatic stalled_traffic();
        addr_t a;
        addr_t b;
        stall = 1'b1;
        for (int i = 0; i < 6; i++) begin
            a = {20'h0, 8'($urandom), 4'h0};
            b = {20'h0, 8'($urandom), 4'h0};
            write_line(a, 16'($urandom), {$urandom, $urandom, $urandom, $urandom});
            read_line(1'b1, a);
            read_line(1'b0, b);
        end
        stall = 1'b0;
    endtask

    initial begin
        #(NUM_TESTS * PER_TEST_NS);
        $display("Watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'ha182_ad81));
        clk     = 1'b0;
        reset_i = 1'b1;
        stall   = 1'b0;
        reverse = 1'b0;
        ic_req  = 1'b0;
        ic_addr = '0;
        dc_req  = 1'b0;
        dc_addr = '0;
        wr_req  = 1'b0;
        wr_addr = '0;
        wr_strb = '0;
        wr_data = '0;
        checks  = 0;
        errors  = 0;
        repeat (4) @(negedge clk);
        reset_i = 1'b0;
        #2;
        reset_state();
        icache_fetch();
        write_then_read();
        dual_read();
        stalled_traffic();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: axi_bridge.f
+incdir+hdl
hdl/axi_bridge_pkg.sv
hdl/cache_bus_if.sv
hdl/axi_read_engine.sv
hdl/axi_write_engine.sv
hdl/axi_bridge.sv
verification/axi_mem_model.sv
verification/axi_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the axi_bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module axi_bridge_tb \
    -Mdir obj_dir \
    -f axi_bridge.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vaxi_bridge_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi

if ! grep -q "Test completed successfully" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0
